/* clic_hart_ctx.sv */
/*
 * Hart context: privilege, thresholds, enables and mintstatus,
 * level fields raised on interrupt take
 */
`timescale 1ns/1ps
`default_nettype none

module clic_hart_ctx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  clic_pkg::cfg_addr_t   cfg_addr_i,
  input  clic_pkg::cfg_data_t   cfg_wdata_i,
  input  logic                  take_i,       // ID stage took the interrupt
  input  clic_pkg::level_t      take_level_i,
  input  clic_pkg::priv_lvl_t   take_priv_i,
  input  logic                  take_v_i,
  output clic_pkg::priv_lvl_t   priv_lvl_o,
  output logic                  v_o,
  output logic                  sie_o,
  output logic                  vsie_o,
  output logic                  sgeie_o,
  output clic_pkg::vsid_t       vgein_o,
  output logic [clic_pkg::HGEIE_W-1:0] hgeie_o,
  output clic_pkg::level_t      mthresh_o,
  output clic_pkg::level_t      sthresh_o,
  output clic_pkg::level_t      vsthresh_o,
  output clic_pkg::level_t      mil_o,
  output clic_pkg::level_t      sil_o,
  output clic_pkg::level_t      vsil_o
);
  import clic_pkg::*;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_o <= PRIV_LVL_M; // Boot in M mode
      v_o        <= 1'b0;
      sie_o      <= 1'b0;
      vsie_o     <= 1'b0;
      sgeie_o    <= 1'b0;
      vgein_o    <= '0;
      hgeie_o    <= '0;
      mthresh_o  <= '0;
      sthresh_o  <= '0;
      vsthresh_o <= '0;
      mil_o      <= '0;
      sil_o      <= '0;
      vsil_o     <= '0;
    end else begin
      if (cfg_we_i) begin
        case (cfg_addr_i)
          CFG_PRIV: begin
            priv_lvl_o <= priv_lvl_t'(cfg_wdata_i[1:0]);
            v_o        <= cfg_wdata_i[PRIV_V_BIT];
          end
          CFG_MTHRESH:  mthresh_o  <= cfg_wdata_i[LEVEL_W-1:0];
          CFG_STHRESH:  sthresh_o  <= cfg_wdata_i[LEVEL_W-1:0];
          CFG_VSTHRESH: vsthresh_o <= cfg_wdata_i[LEVEL_W-1:0];
          CFG_IRQCTRL: begin
            sie_o   <= cfg_wdata_i[CTRL_SIE_BIT];
            vsie_o  <= cfg_wdata_i[CTRL_VSIE_BIT];
            sgeie_o <= cfg_wdata_i[CTRL_SGEIE_BIT];
            vgein_o <= cfg_wdata_i[CTRL_VGEIN_LSB +: VSID_W];
            hgeie_o <= cfg_wdata_i[CTRL_HGEIE_LSB +: HGEIE_W];
          end
          CFG_MINTSTATUS: begin
            mil_o  <= cfg_wdata_i[MIL_LSB +: LEVEL_W];
            sil_o  <= cfg_wdata_i[SIL_LSB +: LEVEL_W];
            vsil_o <= cfg_wdata_i[VSIL_LSB +: LEVEL_W];
          end
          default: ; // Source window, other block
        endcase
      end
      // Take wins over a same-cycle mintstatus write
      if (take_i) begin
        if (take_priv_i == PRIV_LVL_M) begin
          mil_o <= take_level_i;
        end else if (take_priv_i == PRIV_LVL_S) begin
          if (take_v_i) vsil_o <= take_level_i;
          else          sil_o  <= take_level_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* clic_irq_ctrl.sv */
/*
 * Acceptance of the presented interrupt per mode (M, HS, VS, U),
 * cause packing and in-flight tracking for kill acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module clic_irq_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Hart context
  input  clic_pkg::priv_lvl_t   priv_lvl_i,
  input  logic                  v_i,
  input  logic                  sie_i,
  input  logic                  vsie_i,
  input  logic                  sgeie_i,
  input  clic_pkg::vsid_t       vgein_i,
  input  logic [clic_pkg::HGEIE_W-1:0] hgeie_i,
  input  clic_pkg::level_t      mthresh_i,
  input  clic_pkg::level_t      sthresh_i,
  input  clic_pkg::level_t      vsthresh_i,
  input  clic_pkg::level_t      mil_i,
  input  clic_pkg::level_t      sil_i,
  input  clic_pkg::level_t      vsil_i,
  // Presented interrupt
  input  logic                  irq_valid_i,
  input  logic                  irq_ack_i,     // ID stage took it
  input  clic_pkg::src_id_t     irq_id_i,
  input  clic_pkg::level_t      irq_level_i,
  input  clic_pkg::priv_lvl_t   irq_priv_i,
  input  logic                  irq_v_i,
  input  clic_pkg::vsid_t       irq_vsid_i,
  input  logic                  kill_req_i,
  output logic                  kill_ack_o,
  // ID stage
  output logic                  irq_req_o,
  output clic_pkg::priv_lvl_t   irq_priv_o,
  output logic                  irq_v_o,
  output clic_pkg::cause_t      irq_cause_o,
  output logic                  inflight_o
);
  import clic_pkg::*;

  level_t eff_mthresh, eff_sthresh, eff_vsthresh;
  logic   hge_bit;      // hgeie bit of the target VS
  logic   inflight_q;

  // Effective threshold is the higher of threshold and running level
  assign eff_mthresh  = (mthresh_i  > mil_i)  ? mthresh_i  : mil_i;
  assign eff_sthresh  = (sthresh_i  > sil_i)  ? sthresh_i  : sil_i;
  assign eff_vsthresh = (vsthresh_i > vsil_i) ? vsthresh_i : vsil_i;

  // Only HGEIE_W guests implemented
  assign hge_bit = (irq_vsid_i < HGEIE_W) ?
                   hgeie_i[irq_vsid_i[$clog2(HGEIE_W)-1:0]] : 1'b0;

  // --------------------------------------------------------------------
  // Acceptance
  // --------------------------------------------------------------------
  always_comb begin
    irq_priv_o = irq_priv_i;
    irq_v_o    = 1'b0;
    irq_req_o  = 1'b0;
    case (priv_lvl_i)
      PRIV_LVL_M: begin
        if (irq_priv_i == PRIV_LVL_M) begin
          irq_req_o = irq_valid_i && (irq_level_i > eff_mthresh);
        end
      end
      PRIV_LVL_S: begin
        if (irq_priv_i == PRIV_LVL_M) begin
          irq_req_o = irq_valid_i; // M always preempts S
        end else if (irq_priv_i == PRIV_LVL_S) begin
          if (!v_i) begin
            // Virtual ones ignored in HS mode
            irq_req_o = irq_valid_i && !irq_v_i && sie_i && (irq_level_i > eff_sthresh);
          end else if (!irq_v_i) begin
            irq_req_o = irq_valid_i && (irq_level_i > eff_sthresh); // Host S in VS
          end else if (irq_vsid_i == vgein_i) begin
            // For the running guest
            irq_req_o = irq_valid_i && vsie_i && (irq_level_i > eff_vsthresh);
            irq_v_o   = 1'b1;
          end else begin
            irq_req_o = irq_valid_i && sgeie_i && hge_bit; // Other guest goes to hypervisor
          end
        end
      end
      PRIV_LVL_U: begin
        irq_req_o = irq_valid_i; // Everything above U
        irq_v_o   = irq_v_i;
      end
      default: ;
    endcase
  end

  // Cause packing
  assign irq_cause_o = {1'b1,
                        {(XLEN - 1 - CAUSE_LVL_LSB - LEVEL_W){1'b0}},
                        irq_level_i,
                        {(CAUSE_LVL_LSB - SRC_ID_W){1'b0}},
                        irq_id_i};

  // --------------------------------------------------------------------
  // In-flight tracking
  // --------------------------------------------------------------------
  // Kill only when nothing is inserted and nothing is being requested
  assign kill_ack_o = kill_req_i && !inflight_q && !irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else if (inflight_q) begin
      inflight_q <= !irq_ack_i;
    end else begin
      inflight_q <= irq_req_o;
    end
  end

  assign inflight_o = inflight_q;

  // Arbiter holds the request until the ID stage takes it
  a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (irq_req_o && !irq_ack_i) |=> (irq_valid_i && $stable(irq_id_i))
  ) else $error("presented interrupt changed under a request");

endmodule

`default_nettype wire

/* clic_pkg.sv */
/*
 * Shared definitions for the CLIC interrupt subsystem:
 * widths, typedefs, privilege encoding, config address map, cause layout
 */
`default_nettype none

package clic_pkg;

  // Sizes
  localparam int unsigned NUM_SRC  = 16;
  localparam int unsigned SRC_ID_W = 4;
  localparam int unsigned XLEN     = 32;
  localparam int unsigned LEVEL_W  = 8;
  localparam int unsigned VSID_W   = 6;
  localparam int unsigned HGEIE_W  = 16; // Guest external enables, cut from 64

  typedef logic [LEVEL_W-1:0]  level_t;
  typedef logic [SRC_ID_W-1:0] src_id_t;
  typedef logic [VSID_W-1:0]   vsid_t;
  typedef logic [XLEN-1:0]     cause_t;
  typedef logic [7:0]          cfg_addr_t;
  typedef logic [31:0]         cfg_data_t;

  // RISC-V privilege encodings
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // --------------------------------------------------------------------
  // Config address map
  // --------------------------------------------------------------------
  localparam cfg_addr_t CFG_SRC_BASE   = 8'h00; // Base + id, one word per source
  localparam cfg_addr_t CFG_PRIV       = 8'h40; // priv [1:0], v [2]
  localparam cfg_addr_t CFG_MTHRESH    = 8'h41; // [7:0]
  localparam cfg_addr_t CFG_STHRESH    = 8'h42;
  localparam cfg_addr_t CFG_VSTHRESH   = 8'h43;
  localparam cfg_addr_t CFG_IRQCTRL    = 8'h44; // sie, vsie, sgeie, vgein, hgeie
  localparam cfg_addr_t CFG_MINTSTATUS = 8'h45; // mil, sil, vsil

  // Source control word
  localparam int unsigned SRC_EN_BIT   = 0;
  localparam int unsigned SRC_PRIV_LSB = 1;  // 2:1
  localparam int unsigned SRC_V_BIT    = 3;
  localparam int unsigned SRC_VSID_LSB = 4;  // 9:4
  localparam int unsigned SRC_LVL_LSB  = 16; // 23:16

  // Hart context fields
  localparam int unsigned PRIV_V_BIT    = 2;
  localparam int unsigned CTRL_SIE_BIT  = 0;
  localparam int unsigned CTRL_VSIE_BIT = 1;
  localparam int unsigned CTRL_SGEIE_BIT = 2;
  localparam int unsigned CTRL_VGEIN_LSB = 4;  // 9:4
  localparam int unsigned CTRL_HGEIE_LSB = 16; // 31:16
  localparam int unsigned MIL_LSB  = 24;
  localparam int unsigned SIL_LSB  = 8;
  localparam int unsigned VSIL_LSB = 0;

  // Cause word: [XLEN-1] = 1, [23:16] = level, [15:0] = id zero-extended
  localparam int unsigned CAUSE_LVL_LSB = 16;

endpackage

`default_nettype wire

/* clic_src_arbiter.sv */
/*
 * Source arbiter: highest-level pending source, presented register,
 * kill request when a better candidate appears
 */
`timescale 1ns/1ps
`default_nettype none

module clic_src_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [clic_pkg::NUM_SRC-1:0] pending_i,
  input  clic_pkg::level_t      src_level_i [clic_pkg::NUM_SRC],
  input  clic_pkg::priv_lvl_t   src_priv_i  [clic_pkg::NUM_SRC],
  input  logic                  src_v_i     [clic_pkg::NUM_SRC],
  input  clic_pkg::vsid_t       src_vsid_i  [clic_pkg::NUM_SRC],
  input  logic                  kill_ack_i,    // Controller lets go of presented
  output logic                  irq_valid_o,
  output clic_pkg::src_id_t     irq_id_o,
  output clic_pkg::level_t      irq_level_o,
  output clic_pkg::priv_lvl_t   irq_priv_o,
  output logic                  irq_v_o,
  output clic_pkg::vsid_t       irq_vsid_o,
  output logic                  kill_req_o
);
  import clic_pkg::*;

  // Best candidate, combinational
  logic    best_valid;
  src_id_t best_id;
  level_t  best_level;

  // Presented interrupt
  logic      valid_q;
  src_id_t   id_q;
  level_t    level_q;
  priv_lvl_t priv_q;
  logic      v_q;
  vsid_t     vsid_q;

  logic load; // Presented register takes the candidate

  // --------------------------------------------------------------------
  // Selection
  // --------------------------------------------------------------------
  // Strict compare in ascending id order keeps the lower id on a tie
  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      if (pending_i[i] && (!best_valid || (src_level_i[i] > best_level))) begin
        best_valid = 1'b1;
        best_id    = src_id_t'(i);
        best_level = src_level_i[i];
      end
    end
  end

  // Presented one gone or outranked
  assign kill_req_o = valid_q &&
                      (!best_valid || (best_id != id_q) || (best_level != level_q));

  assign load = !valid_q || kill_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= best_valid; // Drops when nothing is left
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && best_valid) begin // Payload only
      id_q    <= best_id;
      level_q <= best_level;
      priv_q  <= src_priv_i[best_id];
      v_q     <= src_v_i[best_id];
      vsid_q  <= src_vsid_i[best_id];
    end
  end

  assign irq_valid_o = valid_q;
  assign irq_id_o    = id_q;
  assign irq_level_o = level_q;
  assign irq_priv_o  = priv_q;
  assign irq_v_o     = v_q;
  assign irq_vsid_o  = vsid_q;

  // Controller only answers an open request
  a_kill_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    kill_ack_i |-> kill_req_o
  ) else $error("kill_ack without kill_req");

endmodule

`default_nettype wire

/* clic_src_regs.sv */
/*
 * Per-source control words written from the config port,
 * one-flop line synchronizer and enabled pending vector
 */
`timescale 1ns/1ps
`default_nettype none

module clic_src_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  clic_pkg::cfg_addr_t   cfg_addr_i,
  input  clic_pkg::cfg_data_t   cfg_wdata_i,
  input  logic [clic_pkg::NUM_SRC-1:0] src_irq_i,      // Raw level lines
  output logic [clic_pkg::NUM_SRC-1:0] pending_o,      // Synced and enabled
  output clic_pkg::level_t      src_level_o [clic_pkg::NUM_SRC],
  output clic_pkg::priv_lvl_t   src_priv_o  [clic_pkg::NUM_SRC],
  output logic                  src_v_o     [clic_pkg::NUM_SRC],
  output clic_pkg::vsid_t       src_vsid_o  [clic_pkg::NUM_SRC]
);
  import clic_pkg::*;

  logic [NUM_SRC-1:0] irq_q;    // Line sampled once
  logic [NUM_SRC-1:0] enable_q;
  level_t             level_q [NUM_SRC];
  priv_lvl_t          priv_q  [NUM_SRC];
  logic               v_q     [NUM_SRC];
  vsid_t              vsid_q  [NUM_SRC];

  cfg_addr_t wr_off;
  logic      src_win;  // Address falls in the source window
  logic      src_wr;   // Legal source write

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------
  assign wr_off  = cfg_addr_i - CFG_SRC_BASE;
  assign src_win = cfg_we_i && (cfg_addr_i < CFG_PRIV);
  assign src_wr  = src_win && (wr_off < NUM_SRC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q    <= '0;
      enable_q <= '0;
      for (int unsigned i = 0; i < NUM_SRC; i++) begin
        level_q[i] <= '0;
        priv_q[i]  <= PRIV_LVL_M;
        v_q[i]     <= 1'b0;
        vsid_q[i]  <= '0;
      end
    end else begin
      irq_q <= src_irq_i;
      if (src_wr) begin // Whole control word at once
        enable_q[wr_off[SRC_ID_W-1:0]] <= cfg_wdata_i[SRC_EN_BIT];
        level_q[wr_off[SRC_ID_W-1:0]]  <= cfg_wdata_i[SRC_LVL_LSB +: LEVEL_W];
        priv_q[wr_off[SRC_ID_W-1:0]]   <= priv_lvl_t'(cfg_wdata_i[SRC_PRIV_LSB +: 2]);
        v_q[wr_off[SRC_ID_W-1:0]]      <= cfg_wdata_i[SRC_V_BIT];
        vsid_q[wr_off[SRC_ID_W-1:0]]   <= cfg_wdata_i[SRC_VSID_LSB +: VSID_W];
      end
    end
  end

  assign pending_o = irq_q & enable_q; // Disabled sources never pend

  always_comb begin
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      src_level_o[i] = level_q[i];
      src_priv_o[i]  = priv_q[i];
      src_v_o[i]     = v_q[i];
      src_vsid_o[i]  = vsid_q[i];
    end
  end

  // Software stays inside the implemented sources
  a_src_wr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    src_win |-> (wr_off < NUM_SRC)
  ) else $error("config write to source id beyond NUM_SRC");

endmodule

`default_nettype wire

/* clic_top.sv */
/*
 * CLIC subsystem top: source registers, source arbiter,
 * acceptance controller and hart context
 */
`timescale 1ns/1ps
`default_nettype none

module clic_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,     // Single-cycle write strobe
  input  clic_pkg::cfg_addr_t   cfg_addr_i,
  input  clic_pkg::cfg_data_t   cfg_wdata_i,
  input  logic [clic_pkg::NUM_SRC-1:0] src_irq_i,
  input  logic                  irq_ack_i,    // From ID stage
  output logic                  irq_req_o,
  output clic_pkg::priv_lvl_t   irq_priv_o,
  output logic                  irq_v_o,
  output clic_pkg::cause_t      irq_cause_o
);
  import clic_pkg::*;

  // Source registers to arbiter
  logic [NUM_SRC-1:0] pending;
  level_t    src_level [NUM_SRC];
  priv_lvl_t src_priv  [NUM_SRC];
  logic      src_v     [NUM_SRC];
  vsid_t     src_vsid  [NUM_SRC];

  // Arbiter to controller
  logic      irq_valid, irq_v, kill_req, kill_ack;
  src_id_t   irq_id;
  level_t    irq_level;
  priv_lvl_t irq_priv;
  vsid_t     irq_vsid;

  // Hart context
  priv_lvl_t          priv_lvl;
  logic               v, sie, vsie, sgeie;
  vsid_t              vgein;
  logic [HGEIE_W-1:0] hgeie;
  level_t             mthresh, sthresh, vsthresh, mil, sil, vsil;

  logic inflight;
  logic take; // Ack of the interrupt in flight

  assign take = inflight && irq_ack_i;

  clic_src_regs clic_src_regs_inst (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .src_irq_i,
    .pending_o(pending), .src_level_o(src_level), .src_priv_o(src_priv),
    .src_v_o(src_v), .src_vsid_o(src_vsid)
  );

  clic_src_arbiter clic_src_arbiter_inst (
    .clk_i, .rst_ni,
    .pending_i(pending), .src_level_i(src_level), .src_priv_i(src_priv),
    .src_v_i(src_v), .src_vsid_i(src_vsid), .kill_ack_i(kill_ack),
    .irq_valid_o(irq_valid), .irq_id_o(irq_id), .irq_level_o(irq_level),
    .irq_priv_o(irq_priv), .irq_v_o(irq_v), .irq_vsid_o(irq_vsid),
    .kill_req_o(kill_req)
  );

  clic_irq_ctrl clic_irq_ctrl_inst (
    .clk_i, .rst_ni,
    .priv_lvl_i(priv_lvl), .v_i(v), .sie_i(sie), .vsie_i(vsie),
    .sgeie_i(sgeie), .vgein_i(vgein), .hgeie_i(hgeie),
    .mthresh_i(mthresh), .sthresh_i(sthresh), .vsthresh_i(vsthresh),
    .mil_i(mil), .sil_i(sil), .vsil_i(vsil),
    .irq_valid_i(irq_valid), .irq_ack_i, .irq_id_i(irq_id),
    .irq_level_i(irq_level), .irq_priv_i(irq_priv), .irq_v_i(irq_v),
    .irq_vsid_i(irq_vsid), .kill_req_i(kill_req), .kill_ack_o(kill_ack),
    .irq_req_o, .irq_priv_o, .irq_v_o, .irq_cause_o, .inflight_o(inflight)
  );

  // Level, priv and v of the taken interrupt as presented to the ID stage
  clic_hart_ctx clic_hart_ctx_inst (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .take_i(take), .take_level_i(irq_level), .take_priv_i(irq_priv_o),
    .take_v_i(irq_v_o), .priv_lvl_o(priv_lvl), .v_o(v),
    .sie_o(sie), .vsie_o(vsie), .sgeie_o(sgeie), .vgein_o(vgein), .hgeie_o(hgeie),
    .mthresh_o(mthresh), .sthresh_o(sthresh), .vsthresh_o(vsthresh),
    .mil_o(mil), .sil_o(sil), .vsil_o(vsil)
  );

endmodule

`default_nettype wire

/* tb_clic_top.sv */
/*
 * Directed testbench for the CLIC subsystem: the TB plays the ID stage,
 * drives config writes and source lines, checks request, priv, v and cause
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clic_top;
  import clic_pkg::*;

  localparam int unsigned NUM_TESTS = 6;
  localparam int unsigned CYCLE_NS  = 10;

  logic               clk;
  logic               rst_n;
  logic               cfg_we;
  cfg_addr_t          cfg_addr;
  cfg_data_t          cfg_wdata;
  logic [NUM_SRC-1:0] src_irq;
  logic               irq_ack;
  logic               irq_req;
  logic               irq_v;
  priv_lvl_t          irq_priv;
  cause_t             irq_cause;
  integer             seed = 64; // Source ids and levels

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_no(rst_n));

  clic_top clic_top_inst (
    .clk_i(clk), .rst_ni(rst_n), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr),
    .cfg_wdata_i(cfg_wdata), .src_irq_i(src_irq), .irq_ack_i(irq_ack),
    .irq_req_o(irq_req), .irq_priv_o(irq_priv), .irq_v_o(irq_v),
    .irq_cause_o(irq_cause)
  );

  // --------------------------------------------------------------------
  // Failure reporting and compares
  // --------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic compare_req(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic compare_cause(input cause_t got, input cause_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_priv(input priv_lvl_t got, input priv_lvl_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------------------------
  // Reference values and stimulus helpers
  // --------------------------------------------------------------------
  function automatic cause_t expected_cause(input level_t lvl, input src_id_t id);
    cause_t c;
    c          = '0;
    c[XLEN-1]  = 1'b1;     // Interrupt flag
    c[23:16]   = lvl;
    c[15:0]    = 16'(id);  // Zero-extended id
    return c;
  endfunction

  function automatic level_t max_level(input level_t a, input level_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [NUM_SRC-1:0] line_of(input src_id_t id);
    logic [NUM_SRC-1:0] l;
    l     = '0;
    l[id] = 1'b1;
    return l;
  endfunction

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);        // Register updates on this edge
    cfg_we    <= 1'b0;
  endtask

  // Enabled source control word
  task automatic write_source(input src_id_t id, input priv_lvl_t p, input logic v,
                              input vsid_t vsid, input level_t lvl);
    cfg_data_t w;
    w        = '0;
    w[0]     = 1'b1;
    w[2:1]   = p;
    w[3]     = v;
    w[9:4]   = vsid;
    w[23:16] = lvl;
    cfg_write(cfg_addr_t'(CFG_SRC_BASE + id), w);
  endtask

  task automatic set_lines(input logic [NUM_SRC-1:0] lines);
    @(posedge clk);
    src_irq <= lines;
  endtask

  task automatic pulse_ack; // ID stage takes the request
    @(posedge clk);
    irq_ack <= 1'b1;
    @(posedge clk);
    irq_ack <= 1'b0;
  endtask

  // Request low until cycle n after the line edge, exp at cycle n
  task automatic expect_req_at(input int n, input logic exp);
    for (int i = 1; i <= n; i++) begin
      @(posedge clk);
      @(negedge clk);
      compare_req(irq_req, (i == n) ? exp : 1'b0,
                  $sformatf("irq_req_o %0d cycles after the line", i));
    end
  endtask

  task automatic hold_req_low(input int n, input string what);
    repeat (n) begin
      @(negedge clk);
      compare_req(irq_req, 1'b0, what);
    end
  endtask

  task automatic wait_req(input int max_cycles);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!irq_req) begin
      if (waited == max_cycles) begin
        abort_run($sformatf("irq_req_o did not rise within %0d cycles", max_cycles));
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic check_taken(input level_t lvl, input src_id_t id, input priv_lvl_t p);
    compare_cause(irq_cause, expected_cause(lvl, id), "irq_cause_o");
    compare_priv(irq_priv, p, "irq_priv_o");
  endtask

  // Back to the reset context, nothing presented or in flight
  task automatic quiesce;
    cfg_write(CFG_PRIV, cfg_data_t'(PRIV_LVL_M));
    cfg_write(CFG_MTHRESH, 32'hff);   // Nothing acceptable
    set_lines('0);
    pulse_ack;                        // Frees a request in flight
    repeat (4) @(posedge clk);        // Kill empties the arbiter
    cfg_write(CFG_MINTSTATUS, '0);
    cfg_write(CFG_MTHRESH, '0);
    cfg_write(CFG_STHRESH, '0);
    cfg_write(CFG_VSTHRESH, '0);
    cfg_write(CFG_IRQCTRL, '0);
  endtask

  // --------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------
  task automatic test_reset_quiet;
    set_lines('1);
    hold_req_low(10, "irq_req_o with no source enabled");
    quiesce;
  endtask

  task automatic test_m_threshold;
    src_id_t id;
    level_t  lvl, mth, ml;
    logic    fire;
    for (int k = 0; k < 5; k++) begin
      id   = src_id_t'(rand_below(NUM_SRC));
      mth  = level_t'(rand_below(128));
      ml   = level_t'(rand_below(128));
      lvl  = (k == 4) ? max_level(mth, ml) : level_t'(rand_below(256)); // Last one on the edge
      fire = lvl > max_level(mth, ml);
      write_source(id, PRIV_LVL_M, 1'b0, '0, lvl);
      cfg_write(CFG_MTHRESH, cfg_data_t'(mth));
      cfg_write(CFG_MINTSTATUS, cfg_data_t'(ml) << MIL_LSB);
      set_lines(line_of(id));
      expect_req_at(2, fire);
      if (fire) begin
        check_taken(lvl, id, PRIV_LVL_M);
        pulse_ack;
      end else begin
        hold_req_low(4, "irq_req_o at or below the M threshold");
      end
      quiesce;
    end
  endtask

  task automatic test_arbitration;
    src_id_t a, b;
    level_t  la, lb;
    a  = src_id_t'(rand_below(NUM_SRC));
    b  = src_id_t'(a + 1 + rand_below(NUM_SRC - 1)); // Never equal to a
    la = level_t'(1 + rand_below(200));
    lb = level_t'(1 + rand_below(255));
    if (lb == la) lb = la + 1;
    // Higher level wins
    write_source(a, PRIV_LVL_M, 1'b0, '0, la);
    write_source(b, PRIV_LVL_M, 1'b0, '0, lb);
    set_lines(line_of(a) | line_of(b));
    expect_req_at(2, 1'b1);
    if (la > lb) check_taken(la, a, PRIV_LVL_M);
    else         check_taken(lb, b, PRIV_LVL_M);
    pulse_ack;
    quiesce;
    // Tie goes to the lower id
    write_source(a, PRIV_LVL_M, 1'b0, '0, la);
    write_source(b, PRIV_LVL_M, 1'b0, '0, la);
    set_lines(line_of(a) | line_of(b));
    expect_req_at(2, 1'b1);
    check_taken(la, (a < b) ? a : b, PRIV_LVL_M);
    pulse_ack;
    quiesce;
    // Presented but not requested, a better one kills it
    cfg_write(CFG_MTHRESH, 32'd50);
    write_source(a, PRIV_LVL_M, 1'b0, '0, 8'd30);
    write_source(b, PRIV_LVL_M, 1'b0, '0, 8'd100);
    set_lines(line_of(a));
    hold_req_low(4, "irq_req_o below the M threshold");
    set_lines(line_of(a) | line_of(b));
    wait_req(10);
    check_taken(8'd100, b, PRIV_LVL_M);
    pulse_ack;
    quiesce;
  endtask

  task automatic test_s_and_u_modes;
    src_id_t   a;
    level_t    lm;
    priv_lvl_t p;
    a  = src_id_t'(rand_below(NUM_SRC));
    lm = level_t'(rand_below(256));
    // S mode, M source ignores mthresh
    cfg_write(CFG_PRIV, cfg_data_t'(PRIV_LVL_S));
    cfg_write(CFG_MTHRESH, 32'hff);
    write_source(a, PRIV_LVL_M, 1'b0, '0, lm);
    set_lines(line_of(a));
    expect_req_at(2, 1'b1);
    check_taken(lm, a, PRIV_LVL_M);
    pulse_ack;
    quiesce;
    // S source needs sie and a level above sthresh
    cfg_write(CFG_PRIV, cfg_data_t'(PRIV_LVL_S));
    cfg_write(CFG_STHRESH, 32'd50);
    write_source(a, PRIV_LVL_S, 1'b0, '0, 8'd100);
    set_lines(line_of(a));
    hold_req_low(4, "S interrupt with sie clear");
    cfg_write(CFG_STHRESH, 32'd150);
    cfg_write(CFG_IRQCTRL, cfg_data_t'(1) << CTRL_SIE_BIT);
    hold_req_low(2, "S interrupt at or below sthresh");
    cfg_write(CFG_STHRESH, 32'd50);
    @(negedge clk);
    compare_req(irq_req, 1'b1, "S interrupt with sie set above sthresh");
    check_taken(8'd100, a, PRIV_LVL_S);
    pulse_ack;
    quiesce;
    // U mode takes M and S alike, thresholds high
    for (int k = 0; k < 2; k++) begin
      p = (k == 0) ? PRIV_LVL_M : PRIV_LVL_S;
      cfg_write(CFG_PRIV, cfg_data_t'(PRIV_LVL_U));
      cfg_write(CFG_MTHRESH, 32'hff);
      cfg_write(CFG_STHRESH, 32'hff);
      write_source(a, p, 1'b0, '0, lm);
      set_lines(line_of(a));
      expect_req_at(2, 1'b1);
      check_taken(lm, a, p);
      pulse_ack;
      quiesce;
    end
  endtask

  task automatic test_vs_mode;
    src_id_t   a;
    cfg_data_t vs_priv, vgein3;
    a       = src_id_t'(rand_below(NUM_SRC));
    vs_priv = cfg_data_t'(PRIV_LVL_S) | (cfg_data_t'(1) << PRIV_V_BIT);
    vgein3  = cfg_data_t'(3) << CTRL_VGEIN_LSB;   // Running guest is 3
    // Interrupt for the running guest
    cfg_write(CFG_PRIV, vs_priv);
    cfg_write(CFG_VSTHRESH, 32'd20);
    cfg_write(CFG_IRQCTRL, vgein3);
    write_source(a, PRIV_LVL_S, 1'b1, 6'd3, 8'd60);
    set_lines(line_of(a));
    hold_req_low(4, "guest interrupt with vsie clear");
    cfg_write(CFG_VSTHRESH, 32'd80);
    cfg_write(CFG_IRQCTRL, vgein3 | (cfg_data_t'(1) << CTRL_VSIE_BIT));
    hold_req_low(2, "guest interrupt at or below vsthresh");
    cfg_write(CFG_VSTHRESH, 32'd20);
    @(negedge clk);
    compare_req(irq_req, 1'b1, "guest interrupt with vsie set above vsthresh");
    compare_req(irq_v, 1'b1, "irq_v_o for the running guest");
    check_taken(8'd60, a, PRIV_LVL_S);
    pulse_ack;
    quiesce;
    // Interrupt for guest 7, goes to the hypervisor
    cfg_write(CFG_PRIV, vs_priv);
    cfg_write(CFG_IRQCTRL, vgein3 | (cfg_data_t'(1) << (CTRL_HGEIE_LSB + 7)));
    write_source(a, PRIV_LVL_S, 1'b1, 6'd7, 8'd60);
    set_lines(line_of(a));
    hold_req_low(4, "other guest with sgeie clear");
    cfg_write(CFG_IRQCTRL, vgein3 | (cfg_data_t'(1) << CTRL_SGEIE_BIT));
    hold_req_low(2, "other guest with its hgeie bit clear");
    cfg_write(CFG_IRQCTRL, vgein3 | (cfg_data_t'(1) << CTRL_SGEIE_BIT) |
                           (cfg_data_t'(1) << (CTRL_HGEIE_LSB + 7)));
    @(negedge clk);
    compare_req(irq_req, 1'b1, "other guest with sgeie and hgeie set");
    compare_req(irq_v, 1'b0, "irq_v_o for another guest");
    check_taken(8'd60, a, PRIV_LVL_S);
    pulse_ack;
    quiesce;
  endtask

  task automatic test_mil_masking;
    src_id_t a, b, c;
    level_t  lvl;
    a   = src_id_t'(rand_below(NUM_SRC));
    b   = src_id_t'(a + 5);
    c   = src_id_t'(a + 11);
    lvl = level_t'(1 + rand_below(200));
    write_source(a, PRIV_LVL_M, 1'b0, '0, lvl);
    write_source(b, PRIV_LVL_M, 1'b0, '0, lvl);
    write_source(c, PRIV_LVL_M, 1'b0, '0, lvl + 8'd1);
    set_lines(line_of(a));
    expect_req_at(2, 1'b1);
    check_taken(lvl, a, PRIV_LVL_M);
    pulse_ack;                               // mil takes lvl
    hold_req_low(3, "acked M interrupt under its own level");
    set_lines(line_of(b));                   // Replaces a, same level
    hold_req_low(8, "M interrupt at the running level");
    set_lines(line_of(b) | line_of(c));
    wait_req(10);
    check_taken(lvl + 8'd1, c, PRIV_LVL_M);
    pulse_ack;
    quiesce;
  endtask

  // --------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------
  initial begin
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    src_irq   = '0;
    irq_ack   = 1'b0;
    wait (rst_n === 1'b1);
    repeat (2) @(posedge clk);
    test_reset_quiet;
    test_m_threshold;
    test_arbitration;
    test_s_and_u_modes;
    test_vs_mode;
    test_mil_masking;
    $display("all tests passed");
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * CYCLE_NS);   // 200 cycles per test
    abort_run("watchdog expired before the tests completed");
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
 * Testbench clock, 10 ns period, and power-on reset
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;              // Held for 16 cycles
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;              // Released away from the active edge
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verilog.f */
clic_pkg.sv
clic_src_regs.sv
clic_src_arbiter.sv
clic_irq_ctrl.sv
clic_hart_ctx.sv
clic_top.sv
tb_clk_gen.sv
tb_clic_top.sv
